// ==== flist.f ====
+incdir+bench
design/resp_route_pkg.sv
design/resp_sync_fifo.sv
design/resp_level_router.sv
design/resp_dist_top.sv
bench/tb_resp_dist.sv

// ==== bench/tb_resp_model.svh ====
// Bench model for the response tree; random source, per-leaf expected queues and value compare
`ifndef TB_RESP_MODEL_SVH
`define TB_RESP_MODEL_SVH

localparam int num_bundles = resp_route_pkg::num_bundles;
localparam int num_lanes   = resp_route_pkg::num_lanes;
localparam int num_leaves  = num_bundles * num_lanes;
localparam int queue_size  = 1024;

logic [15:0]                   lfsr_state = 16'd61417;
resp_route_pkg::resp_payload_t exp_mem [num_leaves][queue_size];
int                            exp_head [num_leaves];
int                            exp_tail [num_leaves];
int                            exp_count [num_leaves];
int                            got_count [num_leaves];
int                            error_count = 0;
int                            check_count = 0;

// Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic next_bit();
  logic out_bit;
  out_bit = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out_bit) begin
    lfsr_state = lfsr_state ^ 16'hB400;
  end
  return out_bit;
endfunction

function automatic logic [15:0] rand_bits(input int n);
  logic [15:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r[i] = next_bit();
  end
  return r;
endfunction

// Beats still owed to any leaf
function automatic int outstanding();
  int total;
  total = 0;
  for (int i = 0; i < num_leaves; i++) begin
    total = total + (exp_tail[i] - exp_head[i]);
  end
  return total;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
  check_count++;
  if (got !== exp) begin
    error_count++;
    $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
  end
endtask

// A leaf gets a copy when both its bundle bit and its lane bit are set
task automatic push_expected(input resp_route_pkg::resp_payload_t p);
  int leaf;
  for (int b = 0; b < num_bundles; b++) begin
    for (int l = 0; l < num_lanes; l++) begin
      if (p.bundle_mask[b] && p.lane_mask[l]) begin
        leaf = b * num_lanes + l;
        exp_mem[leaf][exp_tail[leaf]] = p;
        exp_tail[leaf] = exp_tail[leaf] + 1;
        exp_count[leaf]++;
      end
    end
  end
endtask

task automatic take_beat(input int leaf, input resp_route_pkg::resp_payload_t p);
  got_count[leaf]++;
  if (exp_head[leaf] == exp_tail[leaf]) begin
    error_count++;
    $display("%0t: leaf %0d delivered a beat with tag %0d that was not addressed to it",
             $time, leaf, p.tag);
  end else begin
    check_value($sformatf("leaf_payload[%0d] at leaf %0d", leaf / num_lanes, leaf),
                p, exp_mem[leaf][exp_head[leaf]]);
    exp_head[leaf] = exp_head[leaf] + 1;
  end
endtask

`endif

// ==== bench/tb_resp_dist.sv ====
// Testbench for the response tree; drives random packets and checks every leaf against the model
`default_nettype none

module tb_resp_dist;

  `include "tb_resp_model.svh"

  localparam int total_beats     = 200 + 200 + 300 + 12;
  localparam int watchdog_cycles = total_beats * 40 + 500;
  localparam int drain_limit     = 2000;
  localparam int quiet_cycles    = 20;
  localparam int hold_cycles     = 60;

  logic                          ap_clk;
  logic                          areset_control;
  logic                          in_valid;
  resp_route_pkg::resp_payload_t in_payload;
  logic                          in_almost_full;
  logic                          setup_busy;
  logic [num_leaves-1:0]         leaf_ready;
  logic [num_leaves-1:0]         leaf_valid;
  resp_route_pkg::resp_payload_t leaf_payload [num_bundles];

  logic [7:0] tag_cnt = 8'd0;
  int         test_err_start;
  int         tests_run = 0;
  int         tests_failed = 0;

  resp_dist_top #(
    .num_bundles(num_bundles),
    .num_lanes  (num_lanes)
  ) dut0 (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .in_valid      (in_valid),
    .in_payload    (in_payload),
    .in_almost_full(in_almost_full),
    .setup_busy    (setup_busy),
    .leaf_ready    (leaf_ready),
    .leaf_valid    (leaf_valid),
    .leaf_payload  (leaf_payload)
  );

  initial begin
    ap_clk = 1'b0;
    forever #2 ap_clk = ~ap_clk;
  end

  // Leaf outputs settle well before the falling edge
  always @(negedge ap_clk) begin
    if (!areset_control) begin
      for (int i = 0; i < num_leaves; i++) begin
        if (leaf_valid[i]) begin
          take_beat(i, leaf_payload[i / num_lanes]);
        end
      end
    end
  end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  function automatic logic [15:0] rand_mask(input int w, input bit multi);
    logic [15:0] m;
    m = '0;
    if (!multi) begin
      m = 16'd1 << rand_bits($clog2(w));
    end else begin
      while (m == '0) begin
        m = rand_bits(w);
      end
    end
    return m;
  endfunction

  task automatic send_packets(input int count, input bit multi, input bit rand_ready);
    int                            sent;
    resp_route_pkg::resp_payload_t p;
    logic [15:0]                   rnd;
    logic [15:0]                   bm;
    logic [15:0]                   lm;
    sent = 0;
    while (sent < count) begin
      @(posedge ap_clk);
      #1;
      if (rand_ready) begin
        rnd = rand_bits(num_leaves);
        leaf_ready = rnd[num_leaves-1:0];
      end
      if (!in_almost_full && next_bit()) begin
        bm = rand_mask(num_bundles, multi);
        lm = rand_mask(num_lanes, multi);
        rnd = rand_bits(16);
        p.bundle_mask = bm[num_bundles-1:0];
        p.lane_mask   = lm[num_lanes-1:0];
        p.tag         = tag_cnt;
        p.data        = rnd;
        in_payload = p;
        in_valid   = 1'b1;
        push_expected(p);
        tag_cnt = tag_cnt + 8'd1;
        sent++;
      end else begin
        in_valid = 1'b0;
      end
    end
    @(posedge ap_clk);
    #1;
    in_valid = 1'b0;
  endtask

  // Runs until every model queue is empty, then watches for strays
  task automatic drain(input bit rand_ready);
    int          n;
    logic [15:0] rnd;
    n = 0;
    while (outstanding() != 0 && n < drain_limit) begin
      @(posedge ap_clk);
      #1;
      if (rand_ready) begin
        rnd = rand_bits(num_leaves);
        leaf_ready = rnd[num_leaves-1:0];
      end
      n++;
    end
    if (outstanding() != 0) begin
      error_count++;
      $display("%0t: %0d expected beats never arrived within %0d drain cycles",
               $time, outstanding(), drain_limit);
    end
    leaf_ready = '1;
    repeat (quiet_cycles) @(posedge ap_clk);
    #1;
  endtask

  task automatic wait_setup_done();
    int n;
    n = 0;
    while (setup_busy && n < 10) begin
      @(posedge ap_clk);
      #1;
      n++;
    end
    if (setup_busy) begin
      error_count++;
      $display("%0t: setup_busy stayed high 10 cycles after reset", $time);
    end
  endtask

  // ------------------------------
  // Test bookkeeping
  // ------------------------------
  task automatic start_test();
    test_err_start = error_count;
    for (int i = 0; i < num_leaves; i++) begin
      exp_count[i] = 0;
      got_count[i] = 0;
    end
  endtask

  task automatic end_test(input string name);
    for (int i = 0; i < num_leaves; i++) begin
      check_value($sformatf("leaf %0d beat count", i), got_count[i], exp_count[i]);
    end
    tests_run++;
    if (error_count == test_err_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, error_count - test_err_start);
    end
  endtask

  initial begin
    int held_got;
    areset_control = 1'b1;
    in_valid       = 1'b0;
    in_payload     = '0;
    leaf_ready     = '1;

    start_test();
    repeat (2) @(posedge ap_clk);
    #1;
    check_value("leaf_valid", leaf_valid, 32'd0);
    check_value("in_almost_full", in_almost_full, 32'd0);
    check_value("setup_busy", setup_busy, 32'd1);
    areset_control = 1'b0;
    wait_setup_done();
    end_test("reset");

    start_test();
    send_packets(200, 1'b0, 1'b0);
    drain(1'b0);
    end_test("unicast");

    start_test();
    send_packets(200, 1'b1, 1'b0);
    drain(1'b0);
    end_test("multicast");

    start_test();
    send_packets(300, 1'b1, 1'b1);
    drain(1'b1);
    end_test("backpressure");

    // Leaf 0 held off while traffic goes in
    start_test();
    leaf_ready    = '1;
    leaf_ready[0] = 1'b0;
    held_got      = got_count[0];
    send_packets(12, 1'b1, 1'b0);
    repeat (hold_cycles) @(posedge ap_clk);
    #1;
    check_value("leaf 0 beats while held", got_count[0], held_got);
    if (exp_tail[0] == exp_head[0]) begin
      error_count++;
      $display("%0t: no packet was addressed to the held leaf", $time);
    end
    leaf_ready = '1;
    drain(1'b0);
    end_test("held leaf");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge ap_clk);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("sim failed");
    $finish;
  end

endmodule : tb_resp_dist

`default_nettype wire

// ==== design/resp_dist_top.sv ====
// Top of the response tree; one bundle router feeding one lane router per bundle
`default_nettype none

module resp_dist_top #(
  parameter int num_bundles = resp_route_pkg::num_bundles,
  parameter int num_lanes   = resp_route_pkg::num_lanes
) (
  input  logic                                ap_clk,
  input  logic                                areset_control,
  input  logic                                in_valid,
  input  resp_route_pkg::resp_payload_t       in_payload,
  output logic                                in_almost_full,
  output logic                                setup_busy,
  input  logic [num_bundles*num_lanes-1:0]    leaf_ready,
  output logic [num_bundles*num_lanes-1:0]    leaf_valid,
  output resp_route_pkg::resp_payload_t       leaf_payload [num_bundles]
);

  logic [num_bundles-1:0]        bundle_valid;
  resp_route_pkg::resp_payload_t bundle_payload;
  logic [num_bundles-1:0]        lane_almost_full;
  logic [num_bundles-1:0]        lane_ready;
  logic [num_bundles-1:0]        lane_busy;
  logic                          bundle_busy;

  // Lane router can take more while below its threshold
  assign lane_ready = ~lane_almost_full;
  assign setup_busy = bundle_busy | (|lane_busy);

  // ------------------------------
  // Bundle level
  // ------------------------------
  resp_level_router #(
    .num_req    (num_bundles),
    .route_level(resp_route_pkg::route_level_bundle)
  ) u_bundle_router (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .in_valid      (in_valid),
    .in_payload    (in_payload),
    .almost_full   (in_almost_full),
    .setup_busy    (bundle_busy),
    .req_ready     (lane_ready),
    .out_valid     (bundle_valid),
    .out_payload   (bundle_payload)
  );

  // ------------------------------
  // Lane level
  // ------------------------------
  for (genvar b = 0; b < num_bundles; b++) begin : g_bundle
    resp_level_router #(
      .num_req    (num_lanes),
      .route_level(resp_route_pkg::route_level_lane)
    ) u_lane_router (
      .ap_clk        (ap_clk),
      .areset_control(areset_control),
      .in_valid      (bundle_valid[b]),
      .in_payload    (bundle_payload),
      .almost_full   (lane_almost_full[b]),
      .setup_busy    (lane_busy[b]),
      .req_ready     (leaf_ready[b*num_lanes +: num_lanes]),
      .out_valid     (leaf_valid[b*num_lanes +: num_lanes]),
      .out_payload   (leaf_payload[b])
    );

    // A leaf beat carries both its bundle and lane bits
    for (genvar l = 0; l < num_lanes; l++) begin : g_leaf_chk
      a_leaf_route : assert property (@(posedge ap_clk) disable iff (areset_control)
        leaf_valid[b*num_lanes+l] |->
          (leaf_payload[b].bundle_mask[b] && leaf_payload[b].lane_mask[l]));
    end
  end

endmodule : resp_dist_top

`default_nettype wire

// ==== design/resp_level_router.sv ====
// One-to-N response router for one tree level; queues packets and multicasts them by route mask
`default_nettype none

module resp_level_router #(
  parameter int num_req     = 2,
  parameter int route_level = 0
) (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  logic                          in_valid,
  input  resp_route_pkg::resp_payload_t in_payload,
  output logic                          almost_full,
  output logic                          setup_busy,
  input  logic [num_req-1:0]            req_ready,
  output logic [num_req-1:0]            out_valid,
  output resp_route_pkg::resp_payload_t out_payload
);

  // ------------------------------
  // Input stage
  // ------------------------------
  logic                          in_valid_reg;
  resp_route_pkg::resp_payload_t in_payload_reg;
  logic [num_req-1:0]            ready_reg;

  // ------------------------------
  // Queue
  // ------------------------------
  logic [resp_route_pkg::payload_width-1:0] fifo_dout;
  logic                                     fifo_empty;
  logic                                     fifo_almost_full;
  logic                                     fifo_rst_busy;
  resp_route_pkg::resp_payload_t            head;
  logic [num_req-1:0]                       head_mask;
  logic                                     pop;
  logic [num_req-1:0]                       pop_mask;

  // ------------------------------
  // Fan-out stage
  // ------------------------------
  logic [num_req-1:0]            fanout_valid;
  resp_route_pkg::resp_payload_t fanout_payload;
  logic [num_req-1:0]            out_mask;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_valid_reg <= 1'b0;
      ready_reg    <= '0;
    end else begin
      in_valid_reg <= in_valid;
      ready_reg    <= req_ready;
    end
  end

  always_ff @(posedge ap_clk) begin
    in_payload_reg <= in_payload;
  end

  resp_sync_fifo #(
    .width            (resp_route_pkg::payload_width),
    .depth            (resp_route_pkg::fifo_depth),
    .almost_full_level(resp_route_pkg::fifo_almost_full_level)
  ) u_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (in_payload_reg),
    .wr_en         (in_valid_reg),
    .rd_en         (pop),
    .dout          (fifo_dout),
    .empty         (fifo_empty),
    .full          (),
    .almost_full   (fifo_almost_full),
    .rst_busy      (fifo_rst_busy)
  );

  assign head = fifo_dout;

  // Route mask of this level
  generate
    if (route_level == resp_route_pkg::route_level_bundle) begin : g_bundle_mask
      assign head_mask = head.bundle_mask[num_req-1:0];
      assign out_mask  = out_payload.bundle_mask[num_req-1:0];
    end else begin : g_lane_mask
      assign head_mask = head.lane_mask[num_req-1:0];
      assign out_mask  = out_payload.lane_mask[num_req-1:0];
    end
  endgenerate

  // Pop only once every addressed requestor is ready
  assign pop      = ~fifo_empty & ~fifo_rst_busy & ((head_mask & ~ready_reg) == '0);
  assign pop_mask = head_mask & {num_req{pop}};

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      fanout_valid <= '0;
      out_valid    <= '0;
    end else begin
      fanout_valid <= pop_mask;
      out_valid    <= fanout_valid;
    end
  end

  // Payload shared by all requestors
  always_ff @(posedge ap_clk) begin
    fanout_payload <= head;
    out_payload    <= fanout_payload;
  end

  // ------------------------------
  // Status back to the sender
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      almost_full <= 1'b0;
      setup_busy  <= 1'b1;
    end else begin
      almost_full <= fifo_almost_full;
      setup_busy  <= fifo_rst_busy;
    end
  end

  // Outputs only name requestors in the mask of the payload they carry
  a_out_in_mask : assert property (@(posedge ap_clk) disable iff (areset_control)
    (out_valid & ~out_mask) == '0);

  // Upstream never queues an unrouted packet
  a_head_mask_set : assert property (@(posedge ap_clk) disable iff (areset_control)
    (!fifo_empty && !fifo_rst_busy) |-> (head_mask != '0));

endmodule : resp_level_router

`default_nettype wire

// ==== design/resp_sync_fifo.sv ====
// Synchronous first-word-fall-through FIFO, used as the packet queue inside each router
`default_nettype none

module resp_sync_fifo #(
  parameter int width             = 28,
  parameter int depth             = 16,
  parameter int almost_full_level = 8
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic [width-1:0] din,
  input  logic             wr_en,
  input  logic             rd_en,
  output logic [width-1:0] dout,
  output logic             empty,
  output logic             full,
  output logic             almost_full,
  output logic             rst_busy
);

  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = $clog2(depth + 1);

  logic [width-1:0] mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic [1:0]       busy_cnt;
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wr_en & ~full;
  assign do_rd = rd_en & ~empty;

  // Head of queue shown without a read cycle
  assign dout        = mem[rd_ptr];
  assign empty       = (count == '0);
  assign full        = (count == cnt_w'(depth));
  assign almost_full = (count >= cnt_w'(almost_full_level));

  // ------------------------------
  // Storage
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + cnt_w'(do_wr) - cnt_w'(do_rd);
    end
  end

  // Busy through reset and two cycles beyond
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      busy_cnt <= 2'd2;
      rst_busy <= 1'b1;
    end else begin
      if (busy_cnt != 2'd0) begin
        busy_cnt <= busy_cnt - 2'd1;
      end
      rst_busy <= (busy_cnt != 2'd0);
    end
  end

  a_no_write_full : assert property (@(posedge ap_clk) disable iff (areset_control)
    !(wr_en && full));
  a_no_read_empty : assert property (@(posedge ap_clk) disable iff (areset_control)
    !(rd_en && empty));

endmodule : resp_sync_fifo

`default_nettype wire

// ==== design/resp_route_pkg.sv ====
// Shared payload layout, route mask widths and FIFO sizing for the response distribution tree
`default_nettype none

package resp_route_pkg;

  // ------------------------------
  // Tree shape
  // ------------------------------
  parameter int num_bundles = 2;
  parameter int num_lanes   = 2;

  // Router level select values
  parameter int route_level_bundle = 0;
  parameter int route_level_lane   = 1;

  // ------------------------------
  // Response payload
  // ------------------------------
  // One route mask per hierarchy level, multi-hot allowed
  typedef struct packed {
    logic [num_bundles-1:0] bundle_mask;
    logic [num_lanes-1:0]   lane_mask;
    logic [7:0]             tag;
    logic [15:0]            data;
  } resp_payload_t;

  parameter int payload_width = $bits(resp_payload_t);

  // ------------------------------
  // Queue sizing
  // ------------------------------
  // Threshold leaves eight slots for beats already in flight upstream
  parameter int fifo_depth             = 16;
  parameter int fifo_almost_full_level = 8;

endpackage : resp_route_pkg

`default_nettype wire
